//--- project.f
rtl/axi_write_pkg.sv
rtl/transfer_planner.sv
rtl/data_aligner.sv
rtl/axi_write_engine.sv
rtl/simple_axi_writer.sv
tests/axi_slave_model.sv
tests/tb_simple_axi_writer.sv

//--- Makefile
TOP = tb_simple_axi_writer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_simple_axi_writer.sv
`timescale 1ns/1ps

module tb_simple_axi_writer;

   localparam int mem_bytes   = 8192;
   localparam int words_est   = 900;  // Client words over all tests, rounded up
   localparam int num_tests   = 6;
   localparam int cycle_limit = 40 * words_est + 200 * num_tests;

   logic clk_i = 1'b0;
   logic rst_i = 1'b1;
   logic m_wvalid = 1'b0;
   logic m_wready;
   logic m_wlast;
   logic awvalid;
   logic awready;
   logic wvalid;
   logic wready;
   logic bready;
   logic bp_en = 1'b0;

   axi_write_pkg::addr_t   m_waddr = '0;
   axi_write_pkg::blen_t   m_wlen = '0;
   axi_write_pkg::data_t   m_wdata = '0;
   axi_write_pkg::aw_req_t aw;
   axi_write_pkg::w_beat_t w;
   axi_write_pkg::addr_t   win_lo = '0;
   axi_write_pkg::addr_t   win_hi = '0;
   axi_write_pkg::addr_t   cur_addr = '0;
   axi_write_pkg::addr_t   next_addr = '0;

   logic [7:0] ref_mem [mem_bytes];
   logic [7:0] stream [$];
   int slave_errors;
   int seed = 87;
   int errors = 0;
   int failed_tests = 0;
   int test_num = 1;
   int err_mark = 0;
   int cycles = 0;
   int beats = 0;
   int aw_beats = 0;
   int bursts = 0;
   int wlast_cnt = 0;
   logic aligned_xfer = 1'b0;

   always #10 clk_i = ~clk_i;

   simple_axi_writer dut0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .m_wvalid_i    (m_wvalid),
      .m_waddr_i     (m_waddr),
      .m_wlen_i      (m_wlen),
      .m_wdata_i     (m_wdata),
      .axi_awready_i (awready),
      .axi_wready_i  (wready),
      .m_wready_o    (m_wready),
      .m_wlast_o     (m_wlast),
      .axi_aw_o      (aw),
      .axi_awvalid_o (awvalid),
      .axi_w_o       (w),
      .axi_wvalid_o  (wvalid),
      .axi_bready_o  (bready)
   );

   axi_slave_model slave0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .bp_en_i   (bp_en),
      .lo_i      (win_lo),
      .hi_i      (win_hi),
      .aw_i      (aw),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .w_i       (w),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .errors_o  (slave_errors)
   );

   always @(posedge clk_i) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Burst chaining, strobes and client handshake
   always @(posedge clk_i) begin
      if (!rst_i) begin
         if (awvalid && awready) begin
            if (bursts == 0) begin
               assert (aw.addr == {cur_addr[31:2], 2'b00}) else begin
                  $display("Mismatch awaddr: got %h, expected %h", aw.addr,
                           {cur_addr[31:2], 2'b00});
                  errors++;
               end
            end else begin
               assert (aw.addr == next_addr) else begin
                  $display("Mismatch awaddr: got %h, expected %h", aw.addr, next_addr);
                  errors++;
               end
            end
            next_addr = aw.addr + ((axi_write_pkg::addr_t'(aw.len) + 1) << 2);
            aw_beats  = aw_beats + int'(aw.len) + 1;
            bursts++;
         end
         if (wvalid && wready) begin
            beats++;
            if (aligned_xfer) begin
               assert (w.strb == 4'hf) else begin
                  $display("Mismatch wstrb: got %h, expected %h", w.strb, 4'hf);
                  errors++;
               end
            end
         end
         if (m_wlast) begin
            wlast_cnt++;
         end
         assert (!(m_wready && !wready)) else begin
            $display("Client word taken while wready was low");
            errors++;
         end
         assert (bready === 1'b1) else begin
            $display("Mismatch bready: got %h, expected %h", bready, 1'b1);
            errors++;
         end
      end
   end

   function automatic axi_write_pkg::data_t word_of(input int idx);
      axi_write_pkg::data_t wd;
      wd = '0;
      for (int j = 0; j < 4; j++) begin
         if (4 * idx + j < stream.size()) begin
            wd[8*j +: 8] = stream[4*idx + j];
         end
      end
      return wd;
   endfunction

   task automatic compare_memory();
      int shown;
      shown = 0;
      for (int i = 0; i < mem_bytes; i++) begin
         if (slave0.mem[i] !== ref_mem[i]) begin
            if (shown < 4) begin
               $display("Mismatch mem[%h]: got %h, expected %h", i, slave0.mem[i], ref_mem[i]);
            end
            shown++;
            errors++;
         end
      end
   endtask

   task automatic run_transfer(input axi_write_pkg::addr_t addr, input int len);
      int word_idx;
      int span_beats;
      bit done;
      stream.delete();
      for (int k = 0; k < len; k++) begin
         stream.push_back(8'($random(seed)));
         ref_mem[13'(addr + axi_write_pkg::addr_t'(k))] = stream[k];
      end
      span_beats   = (int'(addr[1:0]) + len + 3) / 4;
      cur_addr     = addr;
      win_lo       = addr;
      win_hi       = addr + axi_write_pkg::addr_t'(len);
      aligned_xfer = (addr[1:0] == 2'b00) && (len % 4 == 0);
      beats        = 0;
      aw_beats     = 0;
      bursts       = 0;
      wlast_cnt    = 0;
      word_idx     = 0;
      done         = 1'b0;
      @(posedge clk_i);
      m_waddr  <= addr;
      m_wlen   <= axi_write_pkg::blen_t'(len);
      m_wdata  <= word_of(0);
      m_wvalid <= 1'b1;
      while (!done) begin
         @(posedge clk_i);
         if (m_wready) begin
            word_idx++;
            m_wdata <= word_of(word_idx);
         end
         if (m_wlast) begin
            done = 1'b1;
            m_wvalid <= 1'b0;
         end
      end
      @(posedge clk_i);
      if (beats != span_beats || aw_beats != span_beats) begin
         $display("Mismatch beat count: got %h W and %h AW, expected %h",
                  beats, aw_beats, span_beats);
         errors++;
      end
      if (wlast_cnt != 1) begin
         $display("Client last pulsed %0d times in one transfer", wlast_cnt);
         errors++;
      end
      compare_memory();
   endtask

   task automatic end_test(input string name);
      int now;
      now = errors + slave_errors;
      $display("test %0d %s: %s", test_num, name, (now == err_mark) ? "ok" : "failed");
      if (now != err_mark) begin
         failed_tests++;
      end
      err_mark = now;
      test_num++;
   endtask

   initial begin
      for (int i = 0; i < mem_bytes; i++) begin
         ref_mem[i] = 8'(i * 7) ^ 8'(i >> 5);
      end
      repeat (16) @(posedge clk_i);
      rst_i <= 1'b0;
      @(posedge clk_i);

      for (int i = 1; i <= 16; i++) begin
         run_transfer(axi_write_pkg::addr_t'(i * 128), 4 * i);
      end
      end_test("aligned");

      for (int off = 0; off < 4; off++) begin
         for (int len = 1; len <= 9; len++) begin
            run_transfer(axi_write_pkg::addr_t'(32'h400 + 16 * (off * 9 + len - 1) + off), len);
         end
      end
      end_test("unaligned short");

      run_transfer(32'h800, 400);
      run_transfer(32'h1202, 522);
      end_test("long");

      run_transfer(32'hf3a, 300);  // Crosses 0x1000
      end_test("4 KB boundary");

      bp_en <= 1'b1;
      for (int n = 0; n < 6; n++) begin
         run_transfer(axi_write_pkg::addr_t'($random(seed) & 32'h17ff),
                      (($random(seed) & 255) % 200) + 1);
      end
      end_test("back-pressure");

      run_transfer(32'hffd, 250);
      run_transfer(32'h310, 64);
      end_test("wlast and wready");

      $display("tests %0d, failed %0d, errors %0d", test_num - 1, failed_tests,
               errors + slave_errors);
      if (failed_tests == 0 && errors + slave_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- tests/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   bp_en_i,    // Random back-pressure on AW and W
   input  axi_write_pkg::addr_t   lo_i,       // Legal byte range, lo inclusive
   input  axi_write_pkg::addr_t   hi_i,
   input  axi_write_pkg::aw_req_t aw_i,
   input  logic                   awvalid_i,
   output logic                   awready_o,
   input  axi_write_pkg::w_beat_t w_i,
   input  logic                   wvalid_i,
   output logic                   wready_o,
   output int                     errors_o
);

   localparam int mem_bytes = 8192;

   logic [7:0] mem [mem_bytes];

   int seed = 87;
   int errors = 0;

   axi_write_pkg::aw_req_t   aw_prev;
   axi_write_pkg::w_beat_t   w_prev;
   axi_write_pkg::addr_t     burst_addr;
   axi_write_pkg::addr_t     byte_addr;
   axi_write_pkg::beat_cnt_t burst_len;
   axi_write_pkg::beat_cnt_t beat;
   logic aw_hold;
   logic w_hold;
   logic burst_open;
   int   end_off;

   assign errors_o = errors;

   initial begin
      for (int i = 0; i < mem_bytes; i++) begin
         mem[i] = 8'(i * 7) ^ 8'(i >> 5);
      end
   end

   always @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
      end else if (bp_en_i) begin
         awready_o <= ($random(seed) & 3) != 0;  // Ready about 3 cycles in 4
         wready_o  <= ($random(seed) & 3) != 0;
      end else begin
         awready_o <= 1'b1;
         wready_o  <= 1'b1;
      end
   end

   always @(posedge clk_i) begin
      if (rst_i) begin
         aw_hold    = 1'b0;
         w_hold     = 1'b0;
         burst_open = 1'b0;
      end else begin
         if (aw_hold) begin
            assert (awvalid_i && aw_i == aw_prev) else begin
               $display("AW request dropped or changed before awready");
               errors++;
            end
         end
         if (w_hold) begin
            assert (wvalid_i && w_i == w_prev) else begin
               $display("W beat dropped or changed before wready");
               errors++;
            end
         end
         aw_hold = awvalid_i && !awready_o;
         aw_prev = aw_i;
         w_hold  = wvalid_i && !wready_o;
         w_prev  = w_i;

         if (awvalid_i && awready_o) begin
            assert (aw_i.len <= 8'd15) else begin
               $display("Mismatch awlen: got %h, limit %h", aw_i.len, 8'd15);
               errors++;
            end
            end_off = int'(aw_i.addr[11:0]) + (int'(aw_i.len) + 1) * 4;
            assert (end_off <= 4096) else begin
               $display("Burst at %h with awlen %h crosses a 4 KB boundary",
                        aw_i.addr, aw_i.len);
               errors++;
            end
            burst_addr = aw_i.addr;
            burst_len  = aw_i.len;
            beat       = '0;
            burst_open = 1'b1;
         end

         if (wvalid_i && wready_o) begin
            if (!burst_open) begin
               $display("W beat accepted with no open burst");
               errors++;
            end else begin
               assert (w_i.last == (beat == burst_len)) else begin
                  $display("Mismatch wlast: got %h, expected %h", w_i.last, beat == burst_len);
                  errors++;
               end
               for (int lane = 0; lane < 4; lane++) begin
                  if (w_i.strb[lane]) begin
                     byte_addr = burst_addr + (axi_write_pkg::addr_t'(beat) << 2)
                               + axi_write_pkg::addr_t'(lane);
                     assert (byte_addr >= lo_i && byte_addr < hi_i) else begin
                        $display("Byte written at %h outside the transfer range", byte_addr);
                        errors++;
                     end
                     mem[byte_addr[12:0]] = w_i.data[8*lane +: 8];
                  end
               end
               if (beat == burst_len) begin
                  burst_open = 1'b0;
               end
               beat = beat + 8'd1;
            end
         end
      end
   end

endmodule

//--- rtl/simple_axi_writer.sv
`timescale 1ns/1ps

module simple_axi_writer (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   m_wvalid_i,
   input  axi_write_pkg::addr_t   m_waddr_i,
   input  axi_write_pkg::blen_t   m_wlen_i,
   input  axi_write_pkg::data_t   m_wdata_i,
   input  logic                   axi_awready_i,
   input  logic                   axi_wready_i,
   output logic                   m_wready_o,
   output logic                   m_wlast_o,
   output axi_write_pkg::aw_req_t axi_aw_o,
   output logic                   axi_awvalid_o,
   output axi_write_pkg::w_beat_t axi_w_o,
   output logic                   axi_wvalid_o,
   output logic                   axi_bready_o
);

   axi_write_pkg::burst_plan_t plan;
   axi_write_pkg::data_t       aligned;
   axi_write_pkg::offset_t     offset;
   logic start;
   logic next_burst;
   logic consume;
   logic flush;

   assign axi_bready_o = 1'b1;  // Responses are dropped

   transfer_planner planner0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .addr_i       (m_waddr_i),
      .len_i        (m_wlen_i),
      .start_i      (start),
      .next_burst_i (next_burst),
      .plan_o       (plan)
   );

   data_aligner aligner0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .offset_i  (offset),
      .data_i    (m_wdata_i),
      .consume_i (consume),
      .flush_i   (flush),
      .data_o    (aligned)
   );

   axi_write_engine engine0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .m_wvalid_i    (m_wvalid_i),
      .m_waddr_i     (m_waddr_i),
      .m_wlen_i      (m_wlen_i),
      .plan_i        (plan),
      .aligned_i     (aligned),
      .axi_awready_i (axi_awready_i),
      .axi_wready_i  (axi_wready_i),
      .m_wready_o    (m_wready_o),
      .m_wlast_o     (m_wlast_o),
      .start_o       (start),
      .next_burst_o  (next_burst),
      .offset_o      (offset),
      .consume_o     (consume),
      .flush_o       (flush),
      .axi_aw_o      (axi_aw_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_w_o       (axi_w_o),
      .axi_wvalid_o  (axi_wvalid_o)
   );

endmodule

//--- rtl/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       m_wvalid_i,
   input  axi_write_pkg::addr_t       m_waddr_i,
   input  axi_write_pkg::blen_t       m_wlen_i,
   input  axi_write_pkg::burst_plan_t plan_i,
   input  axi_write_pkg::data_t       aligned_i,
   input  logic                       axi_awready_i,
   input  logic                       axi_wready_i,
   output logic                       m_wready_o,
   output logic                       m_wlast_o,
   output logic                       start_o,
   output logic                       next_burst_o,
   output axi_write_pkg::offset_t     offset_o,
   output logic                       consume_o,
   output logic                       flush_o,
   output axi_write_pkg::aw_req_t     axi_aw_o,
   output logic                       axi_awvalid_o,
   output axi_write_pkg::w_beat_t     axi_w_o,
   output logic                       axi_wvalid_o
);

   axi_write_pkg::wr_state_e state;
   axi_write_pkg::aw_req_t   aw_q;
   axi_write_pkg::offset_t   offset_q;
   axi_write_pkg::beat_cnt_t beat_cnt;  // Beat within the burst
   axi_write_pkg::strb_t     strb;

   logic [axi_write_pkg::len_w:0]   len_sum;
   logic [axi_write_pkg::len_w-2:0] words_total;
   logic [axi_write_pkg::len_w-2:0] word_cnt;  // Client words taken so far

   logic awvalid_q;
   logic last_burst_q;
   logic first_beat;
   logic beat_last;
   logic w_fire;
   logic flush_beat;

   // Client words cover the length alone, from lane 0
   assign len_sum = {1'b0, m_wlen_i}
                  + (axi_write_pkg::len_w + 1)'(axi_write_pkg::strb_w - 1);

   always_ff @(posedge clk_i) begin
      if (start_o) begin
         offset_q    <= m_waddr_i[axi_write_pkg::offset_w-1:0];
         words_total <= len_sum[axi_write_pkg::len_w:axi_write_pkg::offset_w];
      end
      if (state == axi_write_pkg::PLAN) begin
         aw_q.addr <= plan_i.addr;
         aw_q.len  <= plan_i.awlen;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state        <= axi_write_pkg::IDLE;
         awvalid_q    <= 1'b0;
         last_burst_q <= 1'b0;
         first_beat   <= 1'b0;
         beat_cnt     <= '0;
         word_cnt     <= '0;
      end else begin
         case (state)
            axi_write_pkg::IDLE: begin
               if (m_wvalid_i) begin
                  word_cnt   <= '0;
                  first_beat <= 1'b1;
                  state      <= axi_write_pkg::PLAN;
               end
            end
            axi_write_pkg::PLAN: begin  // Planner output settled here
               awvalid_q    <= 1'b1;
               last_burst_q <= plan_i.last_burst;
               state        <= axi_write_pkg::ADDR;
            end
            axi_write_pkg::ADDR: begin
               if (axi_awready_i) begin
                  awvalid_q <= 1'b0;
                  beat_cnt  <= '0;
                  state     <= axi_write_pkg::DATA;
               end
            end
            axi_write_pkg::DATA: begin
               if (w_fire) begin
                  beat_cnt   <= beat_cnt + 8'd1;
                  first_beat <= 1'b0;
                  if (!flush_beat) begin
                     word_cnt <= word_cnt + 1'b1;
                  end
                  if (beat_last) begin
                     // Next burst needs a fresh plan
                     state <= last_burst_q ? axi_write_pkg::IDLE : axi_write_pkg::PLAN;
                  end
               end
            end
            default: state <= axi_write_pkg::IDLE;
         endcase
      end
   end

   assign start_o      = (state == axi_write_pkg::IDLE) && m_wvalid_i;
   assign next_burst_o = awvalid_q && axi_awready_i;

   // All client words in, one realigned beat still owed
   assign flush_beat = (state == axi_write_pkg::DATA) && (word_cnt == words_total);

   // Start raises both together to empty the aligner residue
   assign flush_o = flush_beat || start_o;

   assign axi_wvalid_o = (state == axi_write_pkg::DATA) && (m_wvalid_i || flush_beat);
   assign w_fire       = axi_wvalid_o && axi_wready_i;
   assign beat_last    = (beat_cnt == aw_q.len);

   assign consume_o  = (w_fire && !flush_beat) || start_o;
   assign m_wready_o = w_fire && !flush_beat;
   assign m_wlast_o  = w_fire && beat_last && last_burst_q;

   always_comb begin
      if (first_beat) begin
         strb = plan_i.first_strb;
      end else if (last_burst_q && beat_last) begin
         strb = plan_i.last_strb;
      end else begin
         strb = '1;
      end
   end

   always_comb begin
      axi_w_o.data = aligned_i;
      axi_w_o.strb = strb;
      axi_w_o.last = beat_last;
   end

   assign axi_aw_o      = aw_q;
   assign axi_awvalid_o = awvalid_q;
   assign offset_o      = offset_q;

endmodule

//--- rtl/data_aligner.sv
`timescale 1ns/1ps

module data_aligner (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  axi_write_pkg::offset_t offset_i,
   input  axi_write_pkg::data_t   data_i,
   input  logic                   consume_i,
   input  logic                   flush_i,
   output axi_write_pkg::data_t   data_o
);

   // Incoming word placed at its lane offset, spill in the upper half
   logic [2*axi_write_pkg::data_w-1:0] shifted;
   axi_write_pkg::data_t               residue;  // Lanes below offset only

   assign shifted = {{axi_write_pkg::data_w{1'b0}}, data_i} << {offset_i, 3'b000};

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         residue <= '0;
      end else if (consume_i && flush_i) begin
         residue <= '0;  // New transfer starts empty
      end else if (consume_i) begin
         residue <= shifted[2*axi_write_pkg::data_w-1:axi_write_pkg::data_w];
      end
   end

   always_comb begin
      if (flush_i) begin
         data_o = residue;  // Tail bytes with no new word
      end else begin
         data_o = shifted[axi_write_pkg::data_w-1:0] | residue;
      end
   end

endmodule

//--- rtl/transfer_planner.sv
`timescale 1ns/1ps

module transfer_planner (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  axi_write_pkg::addr_t       addr_i,
   input  axi_write_pkg::blen_t       len_i,
   input  logic                       start_i,
   input  logic                       next_burst_i,
   output axi_write_pkg::burst_plan_t plan_o
);

   // Beat counts of a whole transfer fit in len_w-1 bits
   logic [axi_write_pkg::len_w-2:0] remaining;
   logic [axi_write_pkg::len_w-2:0] burst_beats;
   logic [axi_write_pkg::len_w-2:0] total_beats;
   logic [axi_write_pkg::len_w:0]   span;

   // Words left before the 4 KB line ends, 1 to 1024
   logic [axi_write_pkg::boundary_w-axi_write_pkg::offset_w:0] to_boundary;

   axi_write_pkg::addr_t    cur_addr;
   axi_write_pkg::offset_t  start_off;
   axi_write_pkg::offset_t  end_off;
   axi_write_pkg::strb_t    head_mask;
   axi_write_pkg::strb_t    tail_mask;
   axi_write_pkg::strb_t    first_strb_q;
   axi_write_pkg::strb_t    last_strb_q;

   assign start_off = addr_i[axi_write_pkg::offset_w-1:0];
   assign end_off   = start_off + len_i[axi_write_pkg::offset_w-1:0];

   // Offset plus length, rounded up to whole words
   assign span = {1'b0, len_i}
               + (axi_write_pkg::len_w + 1)'(start_off)
               + (axi_write_pkg::len_w + 1)'(axi_write_pkg::strb_w - 1);
   assign total_beats = span[axi_write_pkg::len_w:axi_write_pkg::offset_w];

   always_comb begin
      head_mask = axi_write_pkg::strb_t'('1) << start_off;
      if (end_off == '0) begin
         tail_mask = '1;  // Ends on a word edge
      end else begin
         tail_mask = ~(axi_write_pkg::strb_t'('1) << end_off);
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         last_strb_q <= tail_mask;
         if (total_beats == 1) begin
            first_strb_q <= head_mask & tail_mask;  // Single beat takes both edges
         end else begin
            first_strb_q <= head_mask;
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cur_addr  <= '0;
         remaining <= '0;
      end else if (start_i) begin
         cur_addr  <= {addr_i[axi_write_pkg::addr_w-1:axi_write_pkg::offset_w],
                       {axi_write_pkg::offset_w{1'b0}}};
         remaining <= total_beats;
      end else if (next_burst_i) begin
         cur_addr  <= cur_addr + (axi_write_pkg::addr_t'(burst_beats) << axi_write_pkg::offset_w);
         remaining <= remaining - burst_beats;
      end
   end

   assign to_boundary =
      (axi_write_pkg::boundary_w - axi_write_pkg::offset_w + 1)'(
         1 << (axi_write_pkg::boundary_w - axi_write_pkg::offset_w))
      - {1'b0, cur_addr[axi_write_pkg::boundary_w-1:axi_write_pkg::offset_w]};

   // Smallest of burst cap, remaining beats and room to the boundary
   always_comb begin
      burst_beats = (axi_write_pkg::len_w - 1)'(axi_write_pkg::max_beats);
      if (remaining < burst_beats) begin
         burst_beats = remaining;
      end
      if ((axi_write_pkg::len_w - 1)'(to_boundary) < burst_beats) begin
         burst_beats = (axi_write_pkg::len_w - 1)'(to_boundary);
      end
   end

   always_comb begin
      plan_o.addr       = cur_addr;
      plan_o.awlen      = axi_write_pkg::beat_cnt_t'(burst_beats - 1);
      plan_o.first_strb = first_strb_q;
      plan_o.last_strb  = last_strb_q;
      plan_o.last_burst = (remaining == burst_beats);
   end

endmodule

//--- rtl/axi_write_pkg.sv
package axi_write_pkg;

   localparam int addr_w     = 32;
   localparam int data_w     = 32;
   localparam int strb_w     = 4;
   localparam int offset_w   = 2;   // Byte lane select bits
   localparam int len_w      = 16;
   localparam int max_beats  = 16;  // INCR cap used by the planner
   localparam int boundary_w = 12;  // 4 KB

   // Fixed AW attributes
   localparam logic [2:0] axi_size       = 3'b010;
   localparam logic [1:0] axi_burst_incr = 2'b01;
   localparam logic [3:0] axi_cache      = 4'h2;
   localparam logic [2:0] axi_prot       = 3'b010;

   typedef logic [addr_w-1:0]   addr_t;
   typedef logic [data_w-1:0]   data_t;
   typedef logic [strb_w-1:0]   strb_t;
   typedef logic [len_w-1:0]    blen_t;
   typedef logic [7:0]          beat_cnt_t;
   typedef logic [offset_w-1:0] offset_t;

   typedef struct packed {
      addr_t     addr;
      beat_cnt_t len;
   } aw_req_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } w_beat_t;

   // Current burst as seen by the engine
   typedef struct packed {
      addr_t     addr;        // Word aligned
      beat_cnt_t awlen;
      strb_t     first_strb;
      strb_t     last_strb;
      logic      last_burst;
   } burst_plan_t;

   typedef enum logic [1:0] {
      IDLE,
      PLAN,
      ADDR,
      DATA
   } wr_state_e;

endpackage
